// ==== Makefile ====
# Verilator build and run of the processor testbench

VERILATOR ?= verilator
TOP       ?= procTb
SEED      ?= 39240
LOG       ?= sim.log
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir_$(TOP)_$(SEED)
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, the file list or this file changes
$(BIN): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSeed=$(SEED) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf obj_dir_* $(LOG)

// ==== design/decodeStage.sv ====
// ==============================
// Decode stage
// Control decode, register reads, ID/EX register
// ==============================
`timescale 1ns/10ps

module decodeStage (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [procPkg::DataWidth-1:0]    ifInstr,
   input  logic                             ifValid,
   input  logic                             stall,
   input  logic                             wrEn,
   input  logic [procPkg::RegAddrWidth-1:0] wrAddr,
   input  logic [procPkg::DataWidth-1:0]    wrData,
   output logic [procPkg::RegAddrWidth-1:0] srcA,
   output logic [procPkg::RegAddrWidth-1:0] srcB,
   output logic                             usesA,
   output logic                             usesB,
   output logic [procPkg::DataWidth-1:0]    exOperandA,
   output logic [procPkg::DataWidth-1:0]    exOperandB,
   output logic [procPkg::DataWidth-1:0]    exImm,
   output procPkg::aluOpT                   exAluOp,
   output logic                             exUseImm,
   output logic                             exMemRead,
   output logic                             exMemWrite,
   output logic                             exRegWrite,
   output logic [procPkg::RegAddrWidth-1:0] exDest,
   output logic                             exHalt,
   output logic [procPkg::RegAddrWidth-1:0] exSrcA,
   output logic [procPkg::RegAddrWidth-1:0] exSrcB,
   output logic                             exUsesA
);

   procPkg::opcodeT                   opcode;
   procPkg::aluOpT                    aluOp;
   logic [procPkg::DataWidth-1:0]     rdDataA;
   logic [procPkg::DataWidth-1:0]     rdDataB;
   logic [procPkg::DataWidth-1:0]     imm5;
   logic [procPkg::DataWidth-1:0]     imm8;
   logic [procPkg::DataWidth-1:0]     imm;
   logic [procPkg::RegAddrWidth-1:0]  dest;
   logic                              useImm;
   logic                              memRead;
   logic                              memWrite;
   logic                              regWrite;
   logic                              halt;

   registerFile i_registerFile (
      .clk     (clk),
      .reset   (reset),
      .rdAddrA (srcA),
      .rdAddrB (srcB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData)
   );

   assign opcode = procPkg::opcodeT'(ifInstr[procPkg::OpMsb:procPkg::OpLsb]);
   assign srcA   = ifInstr[procPkg::RsMsb:procPkg::RsLsb];
   assign srcB   = ifInstr[procPkg::RtMsb:procPkg::RtLsb];
   assign imm5   = {{(procPkg::DataWidth - procPkg::Imm5Width){ifInstr[procPkg::Imm5Width-1]}},
                    ifInstr[procPkg::Imm5Width-1:0]};
   assign imm8   = {{(procPkg::DataWidth - procPkg::Imm8Width){ifInstr[procPkg::Imm8Width-1]}},
                    ifInstr[procPkg::Imm8Width-1:0]};

   always_comb begin
      usesA    = 1'b0;
      usesB    = 1'b0;
      useImm   = 1'b1;
      memRead  = 1'b0;
      memWrite = 1'b0;
      regWrite = 1'b0;
      halt     = 1'b0;
      aluOp    = procPkg::AluAdd;
      imm      = imm5;
      dest     = srcB;
      if (ifValid) begin
         case (opcode)
            procPkg::OpAluR: begin
               usesA    = 1'b1;
               usesB    = 1'b1;
               useImm   = 1'b0;
               regWrite = 1'b1;
               aluOp    = procPkg::aluOpT'(ifInstr[procPkg::AluOpMsb:procPkg::AluOpLsb]);
               dest     = ifInstr[procPkg::RdMsb:procPkg::RdLsb];
            end
            procPkg::OpAddi: begin
               usesA    = 1'b1;
               regWrite = 1'b1;
            end
            procPkg::OpLd: begin
               usesA    = 1'b1;
               memRead  = 1'b1;
               regWrite = 1'b1;
            end
            procPkg::OpSt: begin
               usesA    = 1'b1;
               usesB    = 1'b1;
               memWrite = 1'b1;
            end
            // Zero plus imm8 into rs
            procPkg::OpLbi: begin
               regWrite = 1'b1;
               imm      = imm8;
               dest     = srcA;
            end
            procPkg::OpHalt: halt = 1'b1;
            default: ;
         endcase
      end
   end

   // ID/EX control, a stall loads a bubble
   always_ff @(posedge clk) begin
      if (reset || stall) begin
         exMemRead  <= 1'b0;
         exMemWrite <= 1'b0;
         exRegWrite <= 1'b0;
         exHalt     <= 1'b0;
         exUsesA    <= 1'b0;
      end else begin
         exMemRead  <= memRead;
         exMemWrite <= memWrite;
         exRegWrite <= regWrite;
         exHalt     <= halt;
         exUsesA    <= usesA;
      end
   end

   always_ff @(posedge clk) begin
      exOperandA <= usesA ? rdDataA : '0;
      exOperandB <= rdDataB;
      exImm      <= imm;
      exAluOp    <= aluOp;
      exUseImm   <= useImm;
      exDest     <= dest;
      exSrcA     <= srcA;
      exSrcB     <= srcB;
   end

endmodule

// ==== design/executeStage.sv ====
// ==============================
// Execute stage
// Forwarding muxes, ALU, EX/MEM register
// ==============================
`timescale 1ns/10ps

module executeStage (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [procPkg::DataWidth-1:0]    exOperandA,
   input  logic [procPkg::DataWidth-1:0]    exOperandB,
   input  logic [procPkg::DataWidth-1:0]    exImm,
   input  procPkg::aluOpT                   exAluOp,
   input  logic                             exUseImm,
   input  logic                             exMemRead,
   input  logic                             exMemWrite,
   input  logic                             exRegWrite,
   input  logic [procPkg::RegAddrWidth-1:0] exDest,
   input  logic                             exHalt,
   input  procPkg::fwdSelT                  fwdA,
   input  procPkg::fwdSelT                  fwdB,
   input  logic [procPkg::DataWidth-1:0]    wbData,
   output logic [procPkg::DataWidth-1:0]    memResult,
   output logic [procPkg::DataWidth-1:0]    memStoreData,
   output logic                             memMemRead,
   output logic                             memMemWrite,
   output logic                             memRegWrite,
   output logic [procPkg::RegAddrWidth-1:0] memDest,
   output logic                             memHalt
);

   logic [procPkg::DataWidth-1:0] operandA;
   logic [procPkg::DataWidth-1:0] operandB;
   logic [procPkg::DataWidth-1:0] aluB;
   logic [procPkg::DataWidth-1:0] aluResult;

   function automatic logic [procPkg::DataWidth-1:0] fwdMux(
      input procPkg::fwdSelT               sel,
      input logic [procPkg::DataWidth-1:0] regValue,
      input logic [procPkg::DataWidth-1:0] memValue,
      input logic [procPkg::DataWidth-1:0] wbValue
   );
      case (sel)
         procPkg::FwdMem: return memValue;
         procPkg::FwdWb:  return wbValue;
         default:         return regValue;
      endcase
   endfunction

   assign operandA = fwdMux(fwdA, exOperandA, memResult, wbData);
   assign operandB = fwdMux(fwdB, exOperandB, memResult, wbData);
   assign aluB     = exUseImm ? exImm : operandB;

   always_comb begin
      case (exAluOp)
         procPkg::AluAdd: aluResult = operandA + aluB;
         procPkg::AluSub: aluResult = aluB - operandA;
         procPkg::AluXor: aluResult = operandA ^ aluB;
         default:         aluResult = operandA & aluB;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         memMemRead  <= 1'b0;
         memMemWrite <= 1'b0;
         memRegWrite <= 1'b0;
         memHalt     <= 1'b0;
      end else begin
         memMemRead  <= exMemRead;
         memMemWrite <= exMemWrite;
         memRegWrite <= exRegWrite;
         memHalt     <= exHalt;
      end
   end

   // Store data is the forwarded rt, not the immediate
   always_ff @(posedge clk) begin
      memResult    <= aluResult;
      memStoreData <= operandB;
      memDest      <= exDest;
   end

endmodule

// ==== design/fetchStage.sv ====
// ==============================
// Fetch stage
// PC, halt freeze and IF/ID register
// ==============================
`timescale 1ns/10ps

module fetchStage (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          stall,
   output logic [procPkg::PcWidth-1:0]   imemAddr,
   input  logic [procPkg::DataWidth-1:0] imemData,
   output logic [procPkg::DataWidth-1:0] ifInstr,
   output logic                          ifValid
);

   logic [procPkg::PcWidth-1:0] pc;
   logic                        haltSeen;
   logic                        fetchHalt;

   assign imemAddr  = pc;
   assign fetchHalt = imemData[procPkg::OpMsb:procPkg::OpLsb] == procPkg::OpHalt;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc       <= '0;
         haltSeen <= 1'b0;
         ifValid  <= 1'b0;
      end else if (!stall) begin
         ifValid <= !haltSeen;
         if (!haltSeen) begin
            // PC stays on the HALT once it is taken
            if (fetchHalt) begin
               haltSeen <= 1'b1;
            end else begin
               pc <= pc + procPkg::PcWidth'(1);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         ifInstr <= haltSeen ? procPkg::NopInstr : imemData;
      end
   end

endmodule

// ==== design/hazardUnit.sv ====
// ==============================
// Hazard unit
// Load-use stall and forwarding selects
// ==============================
`timescale 1ns/10ps

module hazardUnit (
   input  logic [procPkg::RegAddrWidth-1:0] srcA,
   input  logic [procPkg::RegAddrWidth-1:0] srcB,
   input  logic                             usesA,
   input  logic                             usesB,
   input  logic [procPkg::RegAddrWidth-1:0] exSrcA,
   input  logic [procPkg::RegAddrWidth-1:0] exSrcB,
   input  logic                             exUsesA,
   input  logic                             exMemRead,
   input  logic [procPkg::RegAddrWidth-1:0] exDest,
   input  logic                             memRegWrite,
   input  logic [procPkg::RegAddrWidth-1:0] memDest,
   input  logic                             wbRegWrite,
   input  logic [procPkg::RegAddrWidth-1:0] wbDest,
   output logic                             stall,
   output procPkg::fwdSelT                  fwdA,
   output procPkg::fwdSelT                  fwdB
);

   // Youngest producer wins
   function automatic procPkg::fwdSelT pickSource(
      input logic                             used,
      input logic [procPkg::RegAddrWidth-1:0] src,
      input logic                             memWr,
      input logic [procPkg::RegAddrWidth-1:0] memRd,
      input logic                             wbWr,
      input logic [procPkg::RegAddrWidth-1:0] wbRd
   );
      if (used && memWr && memRd == src) begin
         return procPkg::FwdMem;
      end else if (used && wbWr && wbRd == src) begin
         return procPkg::FwdWb;
      end
      return procPkg::FwdNone;
   endfunction

   // Load result is not ready until MEM/WB, hold the consumer one cycle
   assign stall = exMemRead && ((usesA && srcA == exDest) || (usesB && srcB == exDest));

   assign fwdA = pickSource(exUsesA, exSrcA, memRegWrite, memDest, wbRegWrite, wbDest);
   assign fwdB = pickSource(1'b1, exSrcB, memRegWrite, memDest, wbRegWrite, wbDest);

endmodule

// ==== design/memoryStage.sv ====
// ==============================
// Memory stage
// Data memory and MEM/WB register
// ==============================
`timescale 1ns/10ps

module memoryStage (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [procPkg::DataWidth-1:0]    memResult,
   input  logic [procPkg::DataWidth-1:0]    memStoreData,
   input  logic                             memMemRead,
   input  logic                             memMemWrite,
   input  logic                             memRegWrite,
   input  logic [procPkg::RegAddrWidth-1:0] memDest,
   input  logic                             memHalt,
   output logic                             wbEn,
   output logic [procPkg::RegAddrWidth-1:0] wbReg,
   output logic [procPkg::DataWidth-1:0]    wbData,
   output logic                             halted
);

   logic [procPkg::DataWidth-1:0]     dmem [procPkg::DmemDepth];
   logic [procPkg::DmemAddrWidth-1:0] dmemAddr;

   // Low address bits index the memory
   assign dmemAddr = memResult[procPkg::DmemAddrWidth-1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < procPkg::DmemDepth; i++) begin
            dmem[i] <= '0;
         end
      end else if (memMemWrite) begin
         dmem[dmemAddr] <= memStoreData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wbEn   <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbEn   <= memRegWrite;
         halted <= halted || memHalt;
      end
   end

   always_ff @(posedge clk) begin
      wbReg  <= memDest;
      wbData <= memMemRead ? dmem[dmemAddr] : memResult;
   end

endmodule

// ==== design/proc.sv ====
// ==============================
// Processor top
// Five-stage pipeline, external instruction memory
// ==============================
`timescale 1ns/10ps

module proc (
   input  logic                             clk,
   input  logic                             reset,
   output logic [procPkg::PcWidth-1:0]      imemAddr,
   input  logic [procPkg::DataWidth-1:0]    imemData,
   output logic                             wbEn,
   output logic [procPkg::RegAddrWidth-1:0] wbReg,
   output logic [procPkg::DataWidth-1:0]    wbData,
   output logic                             halted
);

   logic                             stall;
   logic [procPkg::DataWidth-1:0]    ifInstr;
   logic                             ifValid;
   logic [procPkg::RegAddrWidth-1:0] srcA;
   logic [procPkg::RegAddrWidth-1:0] srcB;
   logic                             usesA;
   logic                             usesB;
   // ID/EX
   logic [procPkg::DataWidth-1:0]    exOperandA;
   logic [procPkg::DataWidth-1:0]    exOperandB;
   logic [procPkg::DataWidth-1:0]    exImm;
   procPkg::aluOpT                   exAluOp;
   logic                             exUseImm;
   logic                             exMemRead;
   logic                             exMemWrite;
   logic                             exRegWrite;
   logic [procPkg::RegAddrWidth-1:0] exDest;
   logic                             exHalt;
   logic [procPkg::RegAddrWidth-1:0] exSrcA;
   logic [procPkg::RegAddrWidth-1:0] exSrcB;
   logic                             exUsesA;
   procPkg::fwdSelT                  fwdA;
   procPkg::fwdSelT                  fwdB;
   // EX/MEM
   logic [procPkg::DataWidth-1:0]    memResult;
   logic [procPkg::DataWidth-1:0]    memStoreData;
   logic                             memMemRead;
   logic                             memMemWrite;
   logic                             memRegWrite;
   logic [procPkg::RegAddrWidth-1:0] memDest;
   logic                             memHalt;

   fetchStage i_fetchStage (
      .clk(clk), .reset(reset), .stall(stall),
      .imemAddr(imemAddr), .imemData(imemData),
      .ifInstr(ifInstr), .ifValid(ifValid)
   );

   decodeStage i_decodeStage (
      .clk(clk), .reset(reset), .ifInstr(ifInstr), .ifValid(ifValid), .stall(stall),
      .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData),
      .srcA(srcA), .srcB(srcB), .usesA(usesA), .usesB(usesB),
      .exOperandA(exOperandA), .exOperandB(exOperandB), .exImm(exImm), .exAluOp(exAluOp),
      .exUseImm(exUseImm), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
      .exRegWrite(exRegWrite), .exDest(exDest), .exHalt(exHalt),
      .exSrcA(exSrcA), .exSrcB(exSrcB), .exUsesA(exUsesA)
   );

   hazardUnit i_hazardUnit (
      .srcA(srcA), .srcB(srcB), .usesA(usesA), .usesB(usesB),
      .exSrcA(exSrcA), .exSrcB(exSrcB), .exUsesA(exUsesA),
      .exMemRead(exMemRead), .exDest(exDest),
      .memRegWrite(memRegWrite), .memDest(memDest),
      .wbRegWrite(wbEn), .wbDest(wbReg),
      .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
   );

   executeStage i_executeStage (
      .clk(clk), .reset(reset),
      .exOperandA(exOperandA), .exOperandB(exOperandB), .exImm(exImm), .exAluOp(exAluOp),
      .exUseImm(exUseImm), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
      .exRegWrite(exRegWrite), .exDest(exDest), .exHalt(exHalt),
      .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
      .memResult(memResult), .memStoreData(memStoreData), .memMemRead(memMemRead),
      .memMemWrite(memMemWrite), .memRegWrite(memRegWrite), .memDest(memDest),
      .memHalt(memHalt)
   );

   memoryStage i_memoryStage (
      .clk(clk), .reset(reset),
      .memResult(memResult), .memStoreData(memStoreData), .memMemRead(memMemRead),
      .memMemWrite(memMemWrite), .memRegWrite(memRegWrite), .memDest(memDest),
      .memHalt(memHalt),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .halted(halted)
   );

endmodule

// ==== design/procPkg.sv ====
// ==============================
// Processor package
// Widths, depths, opcode and ALU encodings, instruction fields
// ==============================
package procPkg;

   // Datapath and storage sizes
   localparam int DataWidth     = 16;
   localparam int RegAddrWidth  = 3;
   localparam int NumRegs       = 8;
   localparam int PcWidth       = 8;
   localparam int DmemDepth     = 256;
   localparam int DmemAddrWidth = $clog2(DmemDepth);

   // Instruction field positions
   localparam int OpMsb     = 15;
   localparam int OpLsb     = 11;
   localparam int RsMsb     = 10;
   localparam int RsLsb     = 8;
   localparam int RtMsb     = 7;
   localparam int RtLsb     = 5;
   localparam int RdMsb     = 4;
   localparam int RdLsb     = 2;
   localparam int AluOpMsb  = 1;
   localparam int AluOpLsb  = 0;
   localparam int Imm5Width = 5;
   localparam int Imm8Width = 8;

   // Opcodes, anything unlisted decodes as a NOP
   typedef enum logic [4:0] {
      OpHalt = 5'b00000,
      OpNop  = 5'b00001,
      OpAluR = 5'b11011,
      OpAddi = 5'b01000,
      OpLbi  = 5'b11000,
      OpLd   = 5'b10001,
      OpSt   = 5'b10000
   } opcodeT;

   // Register-register ALU function, low two bits of OpAluR
   typedef enum logic [1:0] {
      AluAdd = 2'b00,
      AluSub = 2'b01,
      AluXor = 2'b10,
      AluAnd = 2'b11
   } aluOpT;

   // Operand source for the execute stage
   typedef enum logic [1:0] {
      FwdNone = 2'b00,
      FwdMem  = 2'b01,
      FwdWb   = 2'b10
   } fwdSelT;

   // Filler fed into IF/ID after a HALT
   localparam logic [DataWidth-1:0] NopInstr = {OpNop, 11'd0};

endpackage

// ==== design/registerFile.sv ====
// ==============================
// Register file
// Eight registers, two reads, one write with bypass
// ==============================
`timescale 1ns/10ps

module registerFile (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [procPkg::RegAddrWidth-1:0] rdAddrA,
   input  logic [procPkg::RegAddrWidth-1:0] rdAddrB,
   output logic [procPkg::DataWidth-1:0]    rdDataA,
   output logic [procPkg::DataWidth-1:0]    rdDataB,
   input  logic                             wrEn,
   input  logic [procPkg::RegAddrWidth-1:0] wrAddr,
   input  logic [procPkg::DataWidth-1:0]    wrData
);

   logic [procPkg::DataWidth-1:0] regs [procPkg::NumRegs];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < procPkg::NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Same-cycle write is visible to the reader
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== sim.f ====
design/procPkg.sv
design/registerFile.sv
design/fetchStage.sv
design/decodeStage.sv
design/hazardUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/proc.sv
testbench/procModel.sv
testbench/procTb.sv

// ==== testbench/procModel.sv ====
// ==============================
// Processor reference model
// Random program generator and instruction-level model
// ==============================
package procModel;

   localparam int WbWidth = procPkg::RegAddrWidth + procPkg::DataWidth;
   localparam int BaseReg = 7;
   localparam int RandLen = 120;

   logic [procPkg::DataWidth-1:0] progWords [$];
   // Expected writebacks as {register, value}, in program order
   logic [WbWidth-1:0]            expected [$];

   // Half the sources reuse one of the last two destinations
   function automatic logic [procPkg::RegAddrWidth-1:0] pickSrc(
      input logic [procPkg::RegAddrWidth-1:0] last1,
      input logic [procPkg::RegAddrWidth-1:0] last2
   );
      int pick;
      pick = $urandom_range(0, 3);
      if (pick == 0) begin
         return last1;
      end else if (pick == 1) begin
         return last2;
      end
      return procPkg::RegAddrWidth'($urandom_range(0, procPkg::NumRegs - 1));
   endfunction

   function automatic void genProgram();
      logic [procPkg::RegAddrWidth-1:0] rs;
      logic [procPkg::RegAddrWidth-1:0] rt;
      logic [procPkg::RegAddrWidth-1:0] rd;
      logic [procPkg::RegAddrWidth-1:0] last1;
      logic [procPkg::RegAddrWidth-1:0] last2;
      logic [4:0]                       offset;
      int                               kind;
      progWords.delete();
      last1 = '0;
      last2 = '0;
      for (int r = 0; r < procPkg::NumRegs; r++) begin
         // Small base keeps every load and store address below 64
         if (r == BaseReg) begin
            progWords.push_back({procPkg::OpLbi, 3'(r), 8'(16 + $urandom_range(0, 31))});
         end else begin
            progWords.push_back({procPkg::OpLbi, 3'(r), 8'($urandom)});
         end
      end
      for (int i = 0; i < RandLen; i++) begin
         kind   = $urandom_range(0, 9);
         rs     = pickSrc(last1, last2);
         rt     = pickSrc(last1, last2);
         // Base register is never a destination
         rd     = 3'($urandom_range(0, BaseReg - 1));
         offset = 5'($urandom_range(0, 7) - 4);
         case (kind)
            0, 1, 2, 3: progWords.push_back({procPkg::OpAluR, rs, rt, rd, 2'(kind)});
            4:          progWords.push_back({procPkg::OpAddi, rs, rd, 5'($urandom)});
            5:          progWords.push_back({procPkg::OpLbi, rd, 8'($urandom)});
            6, 7:       progWords.push_back({procPkg::OpLd, 3'(BaseReg), rd, offset});
            8:          progWords.push_back({procPkg::OpSt, 3'(BaseReg), rt, offset});
            default:    progWords.push_back({procPkg::OpNop, 11'd0});
         endcase
         if (kind < 8) begin
            last2 = last1;
            last1 = rd;
         end
      end
      progWords.push_back({procPkg::OpHalt, 11'd0});
   endfunction

   function automatic void runModel();
      logic [procPkg::DataWidth-1:0]     regs [procPkg::NumRegs];
      logic [procPkg::DataWidth-1:0]     dmem [procPkg::DmemDepth];
      logic [procPkg::DataWidth-1:0]     instr;
      logic [procPkg::DataWidth-1:0]     a;
      logic [procPkg::DataWidth-1:0]     b;
      logic [procPkg::DataWidth-1:0]     imm5;
      logic [procPkg::DataWidth-1:0]     value;
      logic [procPkg::DmemAddrWidth-1:0] addr;
      logic [procPkg::RegAddrWidth-1:0]  dest;
      logic                              writes;
      expected.delete();
      foreach (regs[r]) begin
         regs[r] = '0;
      end
      foreach (dmem[d]) begin
         dmem[d] = '0;
      end
      foreach (progWords[i]) begin
         instr  = progWords[i];
         a      = regs[instr[10:8]];
         b      = regs[instr[7:5]];
         imm5   = {{11{instr[4]}}, instr[4:0]};
         addr   = 8'(a + imm5);
         writes = 1'b1;
         dest   = instr[7:5];
         value  = a + imm5;
         if (instr[15:11] == procPkg::OpHalt) begin
            break;
         end
         case (instr[15:11])
            procPkg::OpAluR: begin
               dest = instr[4:2];
               case (instr[1:0])
                  2'b00:   value = a + b;
                  2'b01:   value = b - a;
                  2'b10:   value = a ^ b;
                  default: value = a & b;
               endcase
            end
            procPkg::OpAddi: ;
            procPkg::OpLd:   value = dmem[addr];
            procPkg::OpLbi: begin
               dest  = instr[10:8];
               value = {{8{instr[7]}}, instr[7:0]};
            end
            procPkg::OpSt: begin
               dmem[addr] = b;
               writes     = 1'b0;
            end
            default: writes = 1'b0;
         endcase
         if (writes) begin
            regs[dest] = value;
            expected.push_back({dest, value});
         end
      end
   endfunction

endpackage

// ==== testbench/procTb.sv ====
// ==============================
// Processor testbench
// Random program, writebacks checked against the model
// ==============================
`timescale 1ns/10ps

module procTb #(
   parameter int Seed = 39240
);

   logic                             clk;
   logic                             reset;
   logic [procPkg::PcWidth-1:0]      imemAddr;
   logic [procPkg::DataWidth-1:0]    imemData;
   logic                             wbEn;
   logic [procPkg::RegAddrWidth-1:0] wbReg;
   logic [procPkg::DataWidth-1:0]    wbData;
   logic                             halted;

   logic [procPkg::DataWidth-1:0]    imem [2**procPkg::PcWidth];
   logic [procModel::WbWidth-1:0]    expectQ [$];
   logic [procModel::WbWidth-1:0]    headExp;
   logic                             headValid;
   logic [procPkg::PcWidth-1:0]      haltAddr;
   int                               wbCount;
   int                               expectedCount;
   int                               limitCycles;
   int                               errors;
   int                               timeouts;

   proc i_proc (
      .clk      (clk),
      .reset    (reset),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .wbEn     (wbEn),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .halted   (halted)
   );

   always #2 clk = ~clk;

   assign imemData = imem[imemAddr];

   // Head of the expected list, advanced by each writeback
   always @(posedge clk) begin
      if (reset) begin
         wbCount <= 0;
      end else if (wbEn) begin
         wbCount <= wbCount + 1;
         if (expectQ.size() > 0) begin
            void'(expectQ.pop_front());
         end
      end
      headValid <= expectQ.size() > 0;
      headExp   <= (expectQ.size() > 0) ? expectQ[0] : '0;
   end

   resetQuiet: assert property (@(posedge clk) reset |=> !wbEn && !halted)
      else begin
         errors++;
         $display("mismatch wbEn/halted after reset: got %h/%h, expected 0/0", wbEn, halted);
      end

   noEarlyHalt: assert property (@(posedge clk) disable iff (reset) wbCount == 0 |-> !halted)
      else begin
         errors++;
         $display("halted rose before any instruction retired");
      end

   wbExpected: assert property (@(posedge clk) disable iff (reset) wbEn |-> headValid)
      else begin
         errors++;
         $display("writeback seen after the last expected one");
      end

   wbRegCheck: assert property (@(posedge clk) disable iff (reset)
      wbEn && headValid |-> wbReg == headExp[procModel::WbWidth-1 -: procPkg::RegAddrWidth])
      else begin
         errors++;
         $display("mismatch wbReg: got %h, expected %h", wbReg,
                  headExp[procModel::WbWidth-1 -: procPkg::RegAddrWidth]);
      end

   wbDataCheck: assert property (@(posedge clk) disable iff (reset)
      wbEn && headValid |-> wbData == headExp[procPkg::DataWidth-1:0])
      else begin
         errors++;
         $display("mismatch wbData: got %h, expected %h", wbData,
                  headExp[procPkg::DataWidth-1:0]);
      end

   haltLast: assert property (@(posedge clk) disable iff (reset) $rose(halted) |-> !headValid)
      else begin
         errors++;
         $display("halted rose while expected writebacks were still pending");
      end

   wbTotal: assert property (@(posedge clk) disable iff (reset)
      $rose(halted) |-> wbCount == expectedCount)
      else begin
         errors++;
         $display("mismatch wbCount: got %h, expected %h", wbCount, expectedCount);
      end

   quietAfterHalt: assert property (@(posedge clk) disable iff (reset) halted |-> !wbEn)
      else begin
         errors++;
         $display("writeback seen after halt");
      end

   haltHolds: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
      else begin
         errors++;
         $display("halted dropped before reset");
      end

   // Fetch stays parked on the HALT
   pcFrozen: assert property (@(posedge clk) disable iff (reset)
      halted |-> imemAddr == haltAddr)
      else begin
         errors++;
         $display("mismatch imemAddr: got %h, expected %h", imemAddr, haltAddr);
      end

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      errors      = 0;
      timeouts    = 0;
      limitCycles = 0;
      void'($urandom(Seed));
      procModel::genProgram();
      procModel::runModel();
      for (int a = 0; a < 2**procPkg::PcWidth; a++) begin
         // Beyond the program, a NOP tagged with its own address
         if (a < procModel::progWords.size()) begin
            imem[a] = procModel::progWords[a];
         end else begin
            imem[a] = {procPkg::OpNop, 3'b000, 8'(a)};
         end
      end
      expectQ       = procModel::expected;
      expectedCount = expectQ.size();
      haltAddr      = procPkg::PcWidth'(procModel::progWords.size() - 1);
      limitCycles   = procModel::progWords.size() * 2 + 16 + 50;
      repeat (16) @(posedge clk);
      #0.5 reset = 1'b0;
      while (!halted) begin
         @(posedge clk);
      end
      repeat (20) @(posedge clk);
      $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // Watchdog sized from the program length
   initial begin
      wait (limitCycles > 0);
      repeat (limitCycles) @(posedge clk);
      timeouts++;
      $display("timeout: the processor did not halt within %0d cycles", limitCycles);
      $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
      $display(">>> FAIL");
      $finish;
   end

endmodule
